// File: sources.f
radio_pkg.sv
tx_cmd_if.sv
settings_regs.sv
timekeeper.sv
tx_run_fsm.sv
sample_counter.sv
tx_sample_source.sv
readback_mux.sv
radio_core_top.sv
radio_core_sva.sv
tb_radio_core.sv

// File: Makefile
SRCS := $(shell cat sources.f)

obj_dir/Vtb_radio_core: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_radio_core -f sources.f

run: obj_dir/Vtb_radio_core
	./obj_dir/Vtb_radio_core

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: tb_radio_core.sv
/*
 * Radio core testbench
 * Drives the settings bus, models registers, time and bursts,
 * and compares every output once per cycle
 */
`timescale 1ns/10ps
`default_nettype none

module tb_radio_core;

   localparam int RST_CYCLES = 16;
   localparam int MAX_LEN    = 48;
   localparam int TIMED_LEAD = 30;
   localparam int N_BURSTS   = 10;
   // Setup writes, longest wait and longest burst for every burst
   localparam int MAX_CYCLES = RST_CYCLES + N_BURSTS * (MAX_LEN + TIMED_LEAD + 20) + 200;

   logic                  bus_clk;
   logic                  i_rst;
   logic                  i_set_stb;
   radio_pkg::addr_t      i_set_addr;
   radio_pkg::data_t      i_set_data;
   radio_pkg::data_t      i_rx;
   radio_pkg::data_t      o_tx;
   radio_pkg::time_t      o_rb_data;
   radio_pkg::time_t      o_vita_time;
   logic                  o_run_tx;

   // Reference model state
   radio_pkg::data_t      m_test;
   radio_pkg::data_t      m_idle;
   radio_pkg::data_t      m_cw0;
   radio_pkg::data_t      m_cw1;
   radio_pkg::data_t      m_time_hi;
   radio_pkg::data_t      m_tx;
   radio_pkg::time_t      m_time;
   radio_pkg::time_t      m_cmd_time;
   radio_pkg::time_t      m_start;
   radio_pkg::len_t       m_cmd_len;
   radio_pkg::len_t       m_left;
   radio_pkg::run_state_e m_state;
   logic [2:0]            m_rb_sel;
   logic                  m_cmd_timed;
   logic                  m_cmd_pend;   // SR_CMD write seen last edge
   logic                  m_abort;
   logic                  m_phase;
   int                    cycle_cnt = 0;

   radio_core_top DUT (
      .bus_clk     (bus_clk),
      .i_rst       (i_rst),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .i_rx        (i_rx),
      .o_tx        (o_tx),
      .o_rb_data   (o_rb_data),
      .o_vita_time (o_vita_time),
      .o_run_tx    (o_run_tx)
   );

   always #20 bus_clk = ~bus_clk;

   always @(posedge bus_clk) i_rx <= $urandom;

   //////////////////////////////////////////////////////////////////////
   // Reference model, one step per rising edge
   always @(posedge bus_clk) begin
      if (i_rst) begin
         m_test = '0;
         m_idle = '0;
         m_cw0 = '0;
         m_cw1 = '0;
         m_time_hi = '0;
         m_tx = '0;
         m_time = '0;
         m_cmd_time = '0;
         m_start = '0;
         m_cmd_len = '0;
         m_left = '0;
         m_state = radio_pkg::ST_IDLE;
         m_rb_sel = '0;
         m_cmd_timed = 1'b0;
         m_cmd_pend = 1'b0;
         m_abort = 1'b0;
         m_phase = 1'b0;
      end else begin
         // Output word reflects the run state of the cycle just ended
         if (m_state == radio_pkg::ST_RUN) begin
            m_tx    = m_phase ? m_cw1 : m_cw0;
            m_phase = ~m_phase;
            m_left  = m_left - 16'd1;
         end else begin
            m_tx    = m_idle;
            m_phase = 1'b0;
         end

         if (m_abort)
            m_state = radio_pkg::ST_IDLE;
         else if (m_state == radio_pkg::ST_IDLE && m_cmd_pend && m_cmd_len != '0) begin
            m_left  = m_cmd_len;
            m_start = m_cmd_time;
            m_state = (m_cmd_timed && m_time < m_cmd_time) ? radio_pkg::ST_WAIT
                                                           : radio_pkg::ST_RUN;
         end else if (m_state == radio_pkg::ST_WAIT && m_time >= m_start)
            m_state = radio_pkg::ST_RUN;
         else if (m_state == radio_pkg::ST_RUN && m_left == '0)
            m_state = radio_pkg::ST_IDLE;   // Burst used up

         if (i_set_stb && i_set_addr == radio_pkg::SR_TIME_LO)
            m_time = {m_time_hi, i_set_data};
         else
            m_time = m_time + 64'd1;

         m_cmd_pend = i_set_stb && (i_set_addr == radio_pkg::SR_CMD);
         if (i_set_stb) begin
            case (i_set_addr)
               radio_pkg::SR_TEST:        m_test = i_set_data;
               radio_pkg::SR_CODEC_IDLE:  m_idle = i_set_data;
               radio_pkg::SR_READBACK:    m_rb_sel = i_set_data[2:0];
               radio_pkg::SR_TIME_HI:     m_time_hi = i_set_data;
               radio_pkg::SR_CMD: begin
                  m_cmd_timed = i_set_data[radio_pkg::CMD_TIMED_BIT];
                  m_cmd_len   = i_set_data[15:0];
               end
               radio_pkg::SR_CMD_TIME_HI: m_cmd_time[63:32] = i_set_data;
               radio_pkg::SR_CMD_TIME_LO: m_cmd_time[31:0] = i_set_data;
               radio_pkg::SR_CNTRL:       m_abort = i_set_data[radio_pkg::CNTRL_ABORT_BIT];
               radio_pkg::SR_CODEWORD0:   m_cw0 = i_set_data;
               radio_pkg::SR_CODEWORD1:   m_cw1 = i_set_data;
               default: ;
            endcase
         end
      end
   end

   // Readback word the register map defines for a selector
   function automatic radio_pkg::time_t expected_rb(input logic [2:0] sel,
                                                    input radio_pkg::data_t rx);
      case (sel)
         radio_pkg::RB_TEST:      return {32'd0, m_test};
         radio_pkg::RB_TIME:      return m_time;
         radio_pkg::RB_TXRX:      return {m_tx, rx};
         radio_pkg::RB_STATUS:    return {46'd0, m_state, m_left};
         radio_pkg::RB_CODEWORDS: return {m_cw1, m_cw0};
         default:                 return '0;
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Checking
   task automatic end_with_failure(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic check_data(input string name, input radio_pkg::data_t got,
                             input radio_pkg::data_t exp);
      if (got !== exp)
         end_with_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_time(input string name, input radio_pkg::time_t got,
                             input radio_pkg::time_t exp);
      if (got !== exp)
         end_with_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         end_with_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   always @(negedge bus_clk) begin   // Outputs settled mid-cycle
      if (!i_rst) begin
         check_flag("o_run_tx", o_run_tx, m_state == radio_pkg::ST_RUN);
         check_data("o_tx", o_tx, m_tx);
         check_time("o_vita_time", o_vita_time, m_time);
         check_time("o_rb_data", o_rb_data, expected_rb(m_rb_sel, i_rx));
      end
   end

   always @(posedge bus_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES)
         end_with_failure($sformatf("timeout after %0d cycles", cycle_cnt));
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   task automatic write_reg(input radio_pkg::addr_t addr, input radio_pkg::data_t data);
      i_set_stb  <= 1'b1;
      i_set_addr <= addr;
      i_set_data <= data;
      @(posedge bus_clk);
      i_set_stb  <= 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge bus_clk);
   endtask

   task automatic read_time(output radio_pkg::time_t t);
      @(negedge bus_clk);
      t = o_vita_time;
      @(posedge bus_clk);
   endtask

   // Returns on the rising edge after o_run_tx is seen at level
   task automatic wait_run(input logic level, output radio_pkg::time_t seen,
                           output int waited);
      waited = 0;
      @(negedge bus_clk);
      while (o_run_tx !== level) begin
         waited++;
         @(negedge bus_clk);
      end
      seen = o_vita_time;
      @(posedge bus_clk);
   endtask

   task automatic measure_burst(input int len, output radio_pkg::time_t t_start,
                                output int delay);
      radio_pkg::time_t t_end;
      int               low_wait;
      wait_run(1'b1, t_start, delay);
      wait_run(1'b0, t_end, low_wait);
      check_time("burst length", t_end - t_start, radio_pkg::time_t'(len));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      radio_pkg::time_t t0;
      radio_pkg::time_t t_cmd;
      radio_pkg::data_t val;
      radio_pkg::data_t cw0_v;
      radio_pkg::data_t cw1_v;
      int               len;
      int               delay;

      void'($urandom(54));
      bus_clk    = 1'b0;
      i_rst      = 1'b1;
      i_set_stb  = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_rx       = '0;
      repeat (RST_CYCLES) @(posedge bus_clk);
      i_rst <= 1'b0;
      idle_cycles(2);

      // Register readback
      val   = $urandom;
      cw0_v = $urandom;
      cw1_v = $urandom;
      write_reg(radio_pkg::SR_TEST, val);
      write_reg(radio_pkg::SR_CODEWORD0, cw0_v);
      write_reg(radio_pkg::SR_CODEWORD1, cw1_v);
      write_reg(radio_pkg::SR_READBACK, radio_pkg::data_t'(radio_pkg::RB_TEST));
      @(negedge bus_clk);
      check_time("RB_TEST", o_rb_data, {32'd0, val});
      @(posedge bus_clk);
      write_reg(radio_pkg::SR_READBACK, radio_pkg::data_t'(radio_pkg::RB_CODEWORDS));
      @(negedge bus_clk);
      check_time("RB_CODEWORDS", o_rb_data, {cw1_v, cw0_v});
      @(posedge bus_clk);

      // Time load, kept clear of wrap for the timed bursts
      write_reg(radio_pkg::SR_READBACK, radio_pkg::data_t'(radio_pkg::RB_TIME));
      val = ($urandom & 32'h7fff_ffff) | 32'd1;
      t0  = {val, $urandom};
      write_reg(radio_pkg::SR_TIME_HI, t0[63:32]);
      write_reg(radio_pkg::SR_TIME_LO, t0[31:0]);
      idle_cycles(7);
      @(negedge bus_clk);
      check_time("o_vita_time", o_vita_time, t0 + 64'd7);
      check_time("RB_TIME", o_rb_data, t0 + 64'd7);
      @(posedge bus_clk);

      // Untimed bursts after an empty command
      write_reg(radio_pkg::SR_READBACK, radio_pkg::data_t'(radio_pkg::RB_STATUS));
      write_reg(radio_pkg::SR_CMD, 32'd0);
      idle_cycles(6);
      for (int i = 0; i < 4; i++) begin
         len = (i == 0) ? 1 : 1 + int'($urandom % MAX_LEN);
         write_reg(radio_pkg::SR_CODEC_IDLE, $urandom);
         if (i == 2)
            write_reg(radio_pkg::SR_READBACK, radio_pkg::data_t'(radio_pkg::RB_TXRX));
         write_reg(radio_pkg::SR_CMD, radio_pkg::data_t'(len));
         measure_burst(len, t0, delay);
         check_data("start delay", radio_pkg::data_t'(delay), 32'd1);
         idle_cycles(3);
      end

      // Timed bursts, the last one already due
      for (int i = 0; i < 3; i++) begin
         read_time(t_cmd);
         t_cmd = (i < 2) ? t_cmd + 64'(TIMED_LEAD) : t_cmd - 64'd100;
         len   = 1 + int'($urandom % MAX_LEN);
         write_reg(radio_pkg::SR_CMD_TIME_HI, t_cmd[63:32]);
         write_reg(radio_pkg::SR_CMD_TIME_LO, t_cmd[31:0]);
         write_reg(radio_pkg::SR_CMD, (32'd1 << radio_pkg::CMD_TIMED_BIT) |
                                      radio_pkg::data_t'(len));
         measure_burst(len, t0, delay);
         if (i < 2)
            check_time("o_vita_time at start", t0, t_cmd + 64'd1);
         else
            check_data("start delay", radio_pkg::data_t'(delay), 32'd1);
         idle_cycles(3);
      end

      // Abort mid-burst, then a command that must be ignored
      write_reg(radio_pkg::SR_READBACK, radio_pkg::data_t'(radio_pkg::RB_STATUS));
      write_reg(radio_pkg::SR_CMD, 32'd40);
      wait_run(1'b1, t0, delay);
      idle_cycles(6);
      write_reg(radio_pkg::SR_CNTRL, 32'd1);
      idle_cycles(2);
      write_reg(radio_pkg::SR_CMD, 32'd5);
      idle_cycles(10);
      @(negedge bus_clk);
      check_flag("o_run_tx", o_run_tx, 1'b0);
      @(posedge bus_clk);
      write_reg(radio_pkg::SR_CNTRL, 32'd0);
      idle_cycles(12);

      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: radio_core_sva.sv
/*
 * Radio core assertions
 * Run flag in reset, idle output and abort response
 */
`timescale 1ns/10ps
`default_nettype none

module radio_core_sva (
   input wire                   bus_clk,
   input wire                   i_rst,
   input wire                   i_set_stb,
   input wire radio_pkg::addr_t i_set_addr,
   input wire radio_pkg::data_t i_set_data,
   input wire radio_pkg::data_t i_idle,
   input wire radio_pkg::data_t o_tx,
   input wire                   o_run_tx
);

   logic abort_wr;   // SR_CNTRL write setting abort

   assign abort_wr = i_set_stb && (i_set_addr == radio_pkg::SR_CNTRL) &&
                     i_set_data[radio_pkg::CNTRL_ABORT_BIT];

   a_run_low_in_reset: assert property (@(posedge bus_clk) i_rst |=> !o_run_tx)
      else $error("o_run_tx high after a reset cycle");

   a_idle_when_stopped: assert property (@(posedge bus_clk) disable iff (i_rst)
      !o_run_tx |=> (o_tx == $past(i_idle)))
      else $error("o_tx differs from the idle value");

   // Abort level lands one edge after the write, run drops on the next
   a_abort_stops_run: assert property (@(posedge bus_clk) disable iff (i_rst)
      abort_wr |-> ##2 !o_run_tx)
      else $error("o_run_tx still high after abort");

endmodule

bind radio_core_top radio_core_sva u_sva (
   .bus_clk    (bus_clk),
   .i_rst      (i_rst),
   .i_set_stb  (i_set_stb),
   .i_set_addr (i_set_addr),
   .i_set_data (i_set_data),
   .i_idle     (idle_val),
   .o_tx       (o_tx),
   .o_run_tx   (o_run_tx)
);

`default_nettype wire

// File: radio_core_top.sv
/*
 * Radio core top level
 * Settings bus, timekeeper and timed transmit burst on one clock
 */
`timescale 1ns/10ps
`default_nettype none

module radio_core_top (
   input  wire                      bus_clk,
   input  wire                      i_rst,
   input  wire                      i_set_stb,
   input  wire radio_pkg::addr_t    i_set_addr,
   input  wire radio_pkg::data_t    i_set_data,
   input  wire radio_pkg::data_t    i_rx,
   output radio_pkg::data_t         o_tx,
   output radio_pkg::time_t         o_rb_data,
   output radio_pkg::time_t         o_vita_time,
   output logic                     o_run_tx
);

   radio_pkg::data_t       test_val;
   radio_pkg::data_t       idle_val;
   radio_pkg::data_t       cw0;
   radio_pkg::data_t       cw1;
   radio_pkg::rb_sel_e     rb_sel;
   radio_pkg::run_state_e  run_state;
   radio_pkg::len_t        load_len;
   radio_pkg::len_t        remaining;
   logic                   load;
   logic                   last;

   tx_cmd_if cmd_bus ();

   //////////////////////////////////////////////////////////////////////
   // Settings and time
   settings_regs u_settings_regs (
      .bus_clk    (bus_clk),
      .i_rst      (i_rst),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_cmd      (cmd_bus.src),
      .o_test     (test_val),
      .o_idle     (idle_val),
      .o_cw0      (cw0),
      .o_cw1      (cw1),
      .o_rb_sel   (rb_sel)
   );

   timekeeper u_timekeeper (
      .bus_clk     (bus_clk),
      .i_rst       (i_rst),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .o_vita_time (o_vita_time)
   );

   //////////////////////////////////////////////////////////////////////
   // Transmit path
   tx_run_fsm u_tx_run_fsm (
      .bus_clk     (bus_clk),
      .i_rst       (i_rst),
      .i_cmd       (cmd_bus.dst),
      .i_vita_time (o_vita_time),
      .i_last      (last),
      .o_state     (run_state),
      .o_load      (load),
      .o_len       (load_len),
      .o_run       (o_run_tx)
   );

   sample_counter u_sample_counter (
      .bus_clk     (bus_clk),
      .i_rst       (i_rst),
      .i_load      (load),
      .i_len       (load_len),
      .i_run       (o_run_tx),
      .o_remaining (remaining),
      .o_last      (last)
   );

   tx_sample_source u_tx_sample_source (
      .bus_clk (bus_clk),
      .i_rst   (i_rst),
      .i_run   (o_run_tx),
      .i_cw0   (cw0),
      .i_cw1   (cw1),
      .i_idle  (idle_val),
      .o_tx    (o_tx)
   );

   readback_mux u_readback_mux (
      .i_rb_sel    (rb_sel),
      .i_test      (test_val),
      .i_cw0       (cw0),
      .i_cw1       (cw1),
      .i_tx        (o_tx),
      .i_rx        (i_rx),     // Only seen through readback
      .i_vita_time (o_vita_time),
      .i_state     (run_state),
      .i_remaining (remaining),
      .o_rb_data   (o_rb_data)
   );

endmodule

`default_nettype wire

// File: readback_mux.sv
/*
 * Readback multiplexer
 * Picks the 64-bit readback word from the readback address
 */
`timescale 1ns/10ps
`default_nettype none

module readback_mux (
   input  wire radio_pkg::rb_sel_e     i_rb_sel,
   input  wire radio_pkg::data_t       i_test,
   input  wire radio_pkg::data_t       i_cw0,
   input  wire radio_pkg::data_t       i_cw1,
   input  wire radio_pkg::data_t       i_tx,
   input  wire radio_pkg::data_t       i_rx,
   input  wire radio_pkg::time_t       i_vita_time,
   input  wire radio_pkg::run_state_e  i_state,
   input  wire radio_pkg::len_t        i_remaining,
   output radio_pkg::time_t            o_rb_data
);

   always_comb begin
      case (i_rb_sel)
         radio_pkg::RB_TEST:      o_rb_data = {32'd0, i_test};
         radio_pkg::RB_TIME:      o_rb_data = i_vita_time;
         radio_pkg::RB_TXRX:      o_rb_data = {i_tx, i_rx};
         radio_pkg::RB_STATUS:    o_rb_data = {46'd0, i_state, i_remaining};   // FSM status
         radio_pkg::RB_CODEWORDS: o_rb_data = {i_cw1, i_cw0};
         default:                 o_rb_data = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: tx_sample_source.sv
/*
 * Transmit sample source
 * Alternates the two codewords during a run, idle value otherwise
 */
`timescale 1ns/10ps
`default_nettype none

module tx_sample_source (
   input  wire                      bus_clk,
   input  wire                      i_rst,
   input  wire                      i_run,
   input  wire radio_pkg::data_t    i_cw0,
   input  wire radio_pkg::data_t    i_cw1,
   input  wire radio_pkg::data_t    i_idle,
   output radio_pkg::data_t         o_tx
);

   logic phase;   // 0 selects codeword0

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         phase <= 1'b0;
         o_tx  <= '0;
      end else begin
         // Each burst restarts on codeword0
         phase <= i_run ? ~phase : 1'b0;

         if (i_run)
            o_tx <= phase ? i_cw1 : i_cw0;
         else
            o_tx <= i_idle;
      end
   end

endmodule

`default_nettype wire

// File: sample_counter.sv
/*
 * Burst sample counter
 * Counts down the samples left in the current burst
 */
`timescale 1ns/10ps
`default_nettype none

module sample_counter (
   input  wire                      bus_clk,
   input  wire                      i_rst,
   input  wire                      i_load,
   input  wire radio_pkg::len_t     i_len,
   input  wire                      i_run,
   output radio_pkg::len_t          o_remaining,
   output logic                     o_last
);

   always_ff @(posedge bus_clk) begin
      if (i_rst)
         o_remaining <= '0;
      else if (i_load)
         o_remaining <= i_len;
      else if (i_run)
         o_remaining <= o_remaining - 16'd1;   // One per run cycle
   end

   // Final sample of the burst is under way
   assign o_last = (o_remaining == 16'd1);

endmodule

`default_nettype wire

// File: tx_run_fsm.sv
/*
 * Transmit run FSM
 * Accepts a command when idle, waits for its start time if timed,
 * then runs the burst until the last sample or an abort
 */
`timescale 1ns/10ps
`default_nettype none

module tx_run_fsm (
   input  wire                      bus_clk,
   input  wire                      i_rst,
   tx_cmd_if.dst                    i_cmd,
   input  wire radio_pkg::time_t    i_vita_time,
   input  wire                      i_last,
   output radio_pkg::run_state_e    o_state,
   output logic                     o_load,
   output radio_pkg::len_t          o_len,
   output logic                     o_run
);

   radio_pkg::run_state_e state_nxt;
   radio_pkg::time_t      start_q;
   logic                  accept;
   logic                  due_now;    // Against the incoming command
   logic                  due_wait;   // Against the latched start

   // Zero length and abort both mean no burst
   assign accept   = i_cmd.cmd_stb && !i_cmd.abort && (o_state == radio_pkg::ST_IDLE) &&
                     (i_cmd.cmd_len != '0);
   assign due_now  = (i_vita_time >= i_cmd.cmd_time);
   assign due_wait = (i_vita_time >= start_q);

   always_comb begin
      state_nxt = o_state;
      if (i_cmd.abort) begin
         state_nxt = radio_pkg::ST_IDLE;
      end else begin
         case (o_state)
            radio_pkg::ST_IDLE:
               if (accept)
                  state_nxt = (i_cmd.cmd_timed && !due_now) ? radio_pkg::ST_WAIT
                                                            : radio_pkg::ST_RUN;
            radio_pkg::ST_WAIT:
               if (due_wait) state_nxt = radio_pkg::ST_RUN;
            radio_pkg::ST_RUN:
               if (i_last) state_nxt = radio_pkg::ST_IDLE;
            default: state_nxt = radio_pkg::ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         o_state <= radio_pkg::ST_IDLE;
         start_q <= '0;
      end else begin
         o_state <= state_nxt;
         if (accept) start_q <= i_cmd.cmd_time;
      end
   end

   assign o_load = accept;                       // Counter takes the length now
   assign o_len  = i_cmd.cmd_len;
   assign o_run  = (o_state == radio_pkg::ST_RUN);

endmodule

`default_nettype wire

// File: timekeeper.sv
/*
 * Timekeeper
 * Free running 64-bit time, loaded from the settings bus
 */
`timescale 1ns/10ps
`default_nettype none

module timekeeper (
   input  wire                      bus_clk,
   input  wire                      i_rst,
   input  wire                      i_set_stb,
   input  wire radio_pkg::addr_t    i_set_addr,
   input  wire radio_pkg::data_t    i_set_data,
   output radio_pkg::time_t         o_vita_time
);

   radio_pkg::data_t time_hi_pend;   // Held until the low word arrives

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         time_hi_pend <= '0;
         o_vita_time  <= '0;
      end else begin
         if (i_set_stb && (i_set_addr == radio_pkg::SR_TIME_HI))
            time_hi_pend <= i_set_data;

         // Low word write commits the full time
         if (i_set_stb && (i_set_addr == radio_pkg::SR_TIME_LO))
            o_vita_time <= {time_hi_pend, i_set_data};
         else
            o_vita_time <= o_vita_time + 64'd1;
      end
   end

endmodule

`default_nettype wire

// File: settings_regs.sv
/*
 * Settings register file
 * Decodes settings bus writes into configuration values and
 * the transmit command strobe
 */
`timescale 1ns/10ps
`default_nettype none

module settings_regs (
   input  wire                      bus_clk,
   input  wire                      i_rst,
   input  wire                      i_set_stb,
   input  wire radio_pkg::addr_t    i_set_addr,
   input  wire radio_pkg::data_t    i_set_data,
   tx_cmd_if.src                    o_cmd,
   output radio_pkg::data_t         o_test,
   output radio_pkg::data_t         o_idle,
   output radio_pkg::data_t         o_cw0,
   output radio_pkg::data_t         o_cw1,
   output radio_pkg::rb_sel_e       o_rb_sel
);

   radio_pkg::tx_cmd_t cmd_q;
   logic               cmd_stb_q;
   logic               abort_q;

   //////////////////////////////////////////////////////////////////////
   // Register writes
   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         o_test    <= '0;
         o_idle    <= '0;
         o_cw0     <= '0;
         o_cw1     <= '0;
         o_rb_sel  <= radio_pkg::RB_TEST;
         cmd_q     <= '0;
         cmd_stb_q <= 1'b0;
         abort_q   <= 1'b0;
      end else begin
         cmd_stb_q <= 1'b0;   // Strobe lasts one cycle
         if (i_set_stb) begin
            case (i_set_addr)
               radio_pkg::SR_TEST:       o_test <= i_set_data;
               radio_pkg::SR_CODEC_IDLE: o_idle <= i_set_data;
               radio_pkg::SR_READBACK:   o_rb_sel <= radio_pkg::rb_sel_e'(i_set_data[2:0]);
               radio_pkg::SR_CMD: begin
                  cmd_q.timed <= i_set_data[radio_pkg::CMD_TIMED_BIT];
                  cmd_q.len   <= i_set_data[radio_pkg::LEN_W-1:0];
                  cmd_stb_q   <= 1'b1;
               end
               radio_pkg::SR_CMD_TIME_HI: cmd_q.start[63:32] <= i_set_data;
               radio_pkg::SR_CMD_TIME_LO: cmd_q.start[31:0]  <= i_set_data;
               radio_pkg::SR_CNTRL:      abort_q <= i_set_data[radio_pkg::CNTRL_ABORT_BIT];
               radio_pkg::SR_CODEWORD0:  o_cw0 <= i_set_data;
               radio_pkg::SR_CODEWORD1:  o_cw1 <= i_set_data;
               default: ;   // Other addresses are not ours
            endcase
         end
      end
   end

   // Command bus toward the run FSM
   assign o_cmd.cmd_stb   = cmd_stb_q;
   assign o_cmd.cmd_timed = cmd_q.timed;
   assign o_cmd.cmd_len   = cmd_q.len;
   assign o_cmd.cmd_time  = cmd_q.start;
   assign o_cmd.abort     = abort_q;

endmodule

`default_nettype wire

// File: tx_cmd_if.sv
/*
 * Transmit command bus
 * Carries command strobe, timing, length and abort level to the run FSM
 */
`timescale 1ns/10ps
`default_nettype none

interface tx_cmd_if;

   logic              cmd_stb;     // One cycle per SR_CMD write
   logic              cmd_timed;
   radio_pkg::len_t   cmd_len;
   radio_pkg::time_t  cmd_time;
   logic              abort;       // Level, holds transmit off

   modport src (
      output cmd_stb, cmd_timed, cmd_len, cmd_time, abort
   );

   modport dst (
      input cmd_stb, cmd_timed, cmd_len, cmd_time, abort
   );

endinterface

`default_nettype wire

// File: radio_pkg.sv
/*
 * Radio core shared definitions
 * Settings bus types, register map, readback selectors and FSM states
 */
`default_nettype none

package radio_pkg;

   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;
   localparam int TIME_W = 64;
   localparam int LEN_W  = 16;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [TIME_W-1:0] time_t;   // Also the readback word
   typedef logic [LEN_W-1:0]  len_t;

   //////////////////////////////////////////////////////////////////////
   // Settings bus register map
   localparam addr_t SR_TEST        = 8'd21;
   localparam addr_t SR_CODEC_IDLE  = 8'd22;
   localparam addr_t SR_READBACK    = 8'd32;
   localparam addr_t SR_TIME_HI     = 8'd128;
   localparam addr_t SR_TIME_LO     = 8'd129;
   localparam addr_t SR_CMD         = 8'd160;
   localparam addr_t SR_CMD_TIME_HI = 8'd161;
   localparam addr_t SR_CMD_TIME_LO = 8'd162;
   localparam addr_t SR_CNTRL       = 8'd163;
   localparam addr_t SR_CODEWORD0   = 8'd164;
   localparam addr_t SR_CODEWORD1   = 8'd165;

   localparam int CMD_TIMED_BIT   = 31;   // In SR_CMD data
   localparam int CNTRL_ABORT_BIT = 0;    // In SR_CNTRL data

   typedef enum logic [2:0] {
      RB_TEST      = 3'd0,
      RB_TIME      = 3'd1,
      RB_TXRX      = 3'd2,
      RB_STATUS    = 3'd3,
      RB_CODEWORDS = 3'd4
   } rb_sel_e;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_WAIT = 2'd1,
      ST_RUN  = 2'd2
   } run_state_e;

   // Transmit command as held in the register file
   typedef struct packed {
      logic  timed;
      len_t  len;
      time_t start;
   } tx_cmd_t;

endpackage

`default_nettype wire
